//--- source/fth_pkg.sv
// Sizes assume CHUNKS_PER_LINE and RING_LINES are powers of two so ring indices wrap for free
package fth_pkg;

    // ====================
    // Sizes
    // ====================

    // Width of one stream chunk
    localparam int CHUNK_W = 32;

    // Chunks packed into one host cache line
    localparam int CHUNKS_PER_LINE = 4;

    // Lines in the host ring buffer
    localparam int RING_LINES = 16;

    // Idle stream cycles before an open message is closed
    localparam int IDLE_LIMIT = 16;

    // Granted data lines before an open message is closed
    localparam int LINE_LIMIT = 8;

    // Host line address width
    localparam int ADDR_W = 16;

    // Derived index and counter widths
    localparam int CHUNK_IDX_W = $clog2(CHUNKS_PER_LINE);
    localparam int LINE_IDX_W = $clog2(RING_LINES);
    localparam int COUNT_W = CHUNK_IDX_W + LINE_IDX_W;
    localparam int IDLE_CNT_W = $clog2(IDLE_LIMIT + 1);
    localparam int LINE_CNT_W = $clog2(LINE_LIMIT + 1);

    // ====================
    // Types
    // ====================

    typedef logic [CHUNK_W-1:0] chunk_t;
    typedef logic [CHUNK_IDX_W-1:0] chunk_idx_t;
    typedef logic [LINE_IDX_W-1:0] line_idx_t;

    // Slot 0 holds the oldest chunk of the line
    typedef chunk_t [CHUNKS_PER_LINE-1:0] line_t;

    // Chunks in one message, sized to what the ring can hold
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Commit sequencer states
    typedef enum logic [2:0]
    {
        NORMAL,
        ROTATE,
        EMIT_DATA,
        EMIT_HEADER,
        EMIT_FENCE
    } seq_state_t;

    // Kind of host write
    typedef enum logic [1:0]
    {
        WR_DATA,
        WR_HEADER,
        WR_FENCE
    } wr_kind_t;

    // Write request, held stable until granted
    typedef struct packed
    {
        logic     request;
        wr_kind_t kind;
        addr_t    addr;
        line_t    line;
    } wr_req_t;

    // Packer view shared with the sequencer and the write port
    typedef struct packed
    {
        chunk_idx_t chunk_idx;
        line_idx_t  data_idx;
        logic       header_active;
        count_t     count;
    } pack_status_t;

endpackage

//--- source/fth_chunk_packer.sv
// Source must hold tx_enable low while tx_rdy is low; filler pushed during rotate is undefined
`timescale 1ns/100ps

module fth_chunk_packer
    import fth_pkg::*;
(
    input  logic         clk,
    input  logic         resetb,
    input  chunk_t       tx_data,
    input  logic         tx_enable,
    input  seq_state_t   state,
    input  logic         wr_grant,
    output line_idx_t    next_data_idx,
    output pack_status_t status,
    output line_t        data_line,
    output line_t        header_line
);

    // Slot that the next chunk lands in
    chunk_idx_t chunk_idx;
    chunk_idx_t chunk_idx_next;

    // Ring index of the line being filled
    line_idx_t data_idx;

    // Still filling the header line of the message
    logic header_active;

    // Chunks accepted in this message
    count_t count;

    logic  push;
    logic  last_chunk;
    line_t pushed_line;

    // ====================
    // Shift logic
    // ====================

    // Rotate keeps shifting without a valid chunk
    assign push = tx_enable || (state == ROTATE);

    assign last_chunk = (chunk_idx == chunk_idx_t'(CHUNKS_PER_LINE - 1));

    // New chunk enters at the top, oldest moves toward slot 0
    assign pushed_line = {tx_data, data_line[CHUNKS_PER_LINE-1:1]};

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            data_line <= pushed_line;

            // Header line is parked apart since it is written last
            if (last_chunk && header_active)
            begin
                header_line <= pushed_line;
            end
        end
    end

    // ====================
    // Index tracking
    // ====================

    always_comb
    begin
        chunk_idx_next = chunk_idx;
        next_data_idx = data_idx;

        if (push)
        begin
            if (last_chunk)
            begin
                chunk_idx_next = '0;

                // A full header moves on at once; data lines move on grant
                if (header_active)
                begin
                    next_data_idx = data_idx + 1'b1;
                end
            end
            else
            begin
                chunk_idx_next = chunk_idx + 1'b1;
            end
        end
        else if ((state == EMIT_DATA) && wr_grant)
        begin
            next_data_idx = data_idx + 1'b1;
        end
        else if (state == EMIT_HEADER)
        begin
            // Leave slot 0 of the next header for the count
            chunk_idx_next = chunk_idx_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            chunk_idx <= chunk_idx_t'(1);
            data_idx <= '0;
            header_active <= 1'b1;
            count <= '0;
        end
        else
        begin
            chunk_idx <= chunk_idx_next;
            data_idx <= next_data_idx;

            // Header done once its line fills, reopens after the fence
            if (push && last_chunk)
            begin
                header_active <= 1'b0;
            end
            else if ((state == EMIT_FENCE) && wr_grant)
            begin
                header_active <= 1'b1;
            end

            // count real chunks only, rotate filler does not count
            if (tx_enable)
            begin
                count <= count + 1'b1;
            end
            else if (state == EMIT_FENCE)
            begin
                count <= '0;
            end
        end
    end

    assign status = '{
        chunk_idx: chunk_idx,
        data_idx: data_idx,
        header_active: header_active,
        count: count
    };

endmodule

//--- source/fth_commit_sequencer.sv
// Ring is full when the next data line would reach oldest_line_idx; one line always stays free
`timescale 1ns/100ps

module fth_commit_sequencer
    import fth_pkg::*;
(
    input  logic         clk,
    input  logic         resetb,
    input  pack_status_t status,
    input  logic         tx_enable,
    input  logic         wr_grant,
    input  line_idx_t    next_data_idx,
    input  line_idx_t    oldest_line_idx,
    output seq_state_t   state,
    output line_idx_t    header_idx,
    output logic         tx_rdy
);

    seq_state_t state_next;

    // Idle cycles in NORMAL, saturating at the limit
    logic [IDLE_CNT_W-1:0] idle_cycles;
    logic [IDLE_CNT_W-1:0] idle_cycles_next;

    // Data lines granted in this message
    logic [LINE_CNT_W-1:0] data_lines;
    logic [LINE_CNT_W-1:0] data_lines_next;

    // Sticky request to close the message
    logic flush;
    logic flush_next;

    logic line_full;
    logic has_data;

    assign line_full = (status.chunk_idx == chunk_idx_t'(CHUNKS_PER_LINE - 1));

    // Anything past the count slot of the header means the message is open
    assign has_data = !status.header_active || (status.chunk_idx != chunk_idx_t'(1));

    // ====================
    // Flush triggers
    // ====================

    always_comb
    begin
        if (state != NORMAL)
        begin
            idle_cycles_next = '0;
        end
        else if (tx_enable)
        begin
            idle_cycles_next = '0;
        end
        else if (idle_cycles != IDLE_CNT_W'(IDLE_LIMIT))
        begin
            idle_cycles_next = idle_cycles + 1'b1;
        end
        else
        begin
            idle_cycles_next = idle_cycles;
        end

        // Line count restarts with each header
        if (state == EMIT_HEADER)
        begin
            data_lines_next = '0;
        end
        else if ((state == EMIT_DATA) && wr_grant)
        begin
            data_lines_next = data_lines + 1'b1;
        end
        else
        begin
            data_lines_next = data_lines;
        end

        if (state == EMIT_HEADER)
        begin
            flush_next = 1'b0;
        end
        else if (has_data)
        begin
            flush_next = flush ||
                         (idle_cycles_next == IDLE_CNT_W'(IDLE_LIMIT)) ||
                         (data_lines_next == LINE_CNT_W'(LINE_LIMIT));
        end
        else
        begin
            flush_next = flush;
        end
    end

    // ====================
    // Commit FSM
    // ====================

    always_comb
    begin
        state_next = state;

        case (state)
            NORMAL:
            begin
                if (!status.header_active && tx_enable && line_full)
                begin
                    // Data line fills with this chunk
                    state_next = EMIT_DATA;
                end
                else if (flush)
                begin
                    // Empty line means the last data line is already out
                    if (status.chunk_idx == '0)
                    begin
                        state_next = EMIT_HEADER;
                    end
                    else
                    begin
                        state_next = ROTATE;
                    end
                end
            end

            ROTATE:
            begin
                // Partial line now shifted into place
                if (line_full)
                begin
                    state_next = status.header_active ? EMIT_HEADER : EMIT_DATA;
                end
            end

            EMIT_DATA:
            begin
                if (wr_grant)
                begin
                    state_next = flush ? EMIT_HEADER : NORMAL;
                end
            end

            EMIT_HEADER:
            begin
                if (wr_grant)
                begin
                    state_next = EMIT_FENCE;
                end
            end

            EMIT_FENCE:
            begin
                if (wr_grant)
                begin
                    state_next = NORMAL;
                end
            end

            default:
            begin
                state_next = NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= NORMAL;
            idle_cycles <= '0;
            data_lines <= '0;
            flush <= 1'b0;
            header_idx <= '0;
            tx_rdy <= 1'b0;
        end
        else
        begin
            state <= state_next;
            idle_cycles <= idle_cycles_next;
            data_lines <= data_lines_next;
            flush <= flush_next;

            // Next message starts where this one ended
            if ((state == EMIT_FENCE) && wr_grant)
            begin
                header_idx <= status.data_idx;
            end

            // Looks one cycle ahead
            tx_rdy <= (state_next == NORMAL) &&
                      !flush_next &&
                      (next_data_idx + 1'b1 != oldest_line_idx);
        end
    end

endmodule

//--- source/fth_write_port.sv
// Combinational; request, kind, address and line hold as long as the sequencer state holds
`timescale 1ns/100ps

module fth_write_port
    import fth_pkg::*;
(
    input  seq_state_t   state,
    input  pack_status_t status,
    input  line_idx_t    header_idx,
    input  addr_t        ring_base,
    input  line_t        data_line,
    input  line_t        header_line,
    output wr_req_t      wr_req
);

    // Header with its count slot filled in
    line_t counted_header;

    always_comb
    begin
        counted_header = header_line;
        counted_header[0] = chunk_t'(status.count);

        wr_req.request = (state == EMIT_DATA) ||
                         (state == EMIT_HEADER) ||
                         (state == EMIT_FENCE);

        case (state)
            EMIT_DATA:
            begin
                wr_req.kind = WR_DATA;
                wr_req.addr = ring_base + addr_t'(status.data_idx);
                wr_req.line = data_line;
            end

            EMIT_HEADER:
            begin
                wr_req.kind = WR_HEADER;
                wr_req.addr = ring_base + addr_t'(header_idx);
                wr_req.line = counted_header;
            end

            // Fence has no address
            // Raw header line stays put while the count clears
            default:
            begin
                wr_req.kind = WR_FENCE;
                wr_req.addr = '0;
                wr_req.line = header_line;
            end
        endcase
    end

endmodule

//--- source/fth_top.sv
// Host must keep oldest_line_idx current; a stale value stalls the stream once the ring fills
`timescale 1ns/100ps

module fth_top
    import fth_pkg::*;
(
    input  logic      clk,
    input  logic      resetb,
    input  chunk_t    tx_data,
    input  logic      tx_enable,
    output logic      tx_rdy,
    input  addr_t     ring_base,
    input  line_idx_t oldest_line_idx,
    output wr_req_t   wr_req,
    input  logic      wr_grant,
    output line_idx_t next_write_line_idx
);

    pack_status_t status;
    seq_state_t   state;
    line_idx_t    next_data_idx;
    line_t        data_line;
    line_t        header_line;

    // Packs chunks into lines
    fth_chunk_packer fth_chunk_packer_i (
        .clk           (clk),
        .resetb        (resetb),
        .tx_data       (tx_data),
        .tx_enable     (tx_enable),
        .state         (state),
        .wr_grant      (wr_grant),
        .next_data_idx (next_data_idx),
        .status        (status),
        .data_line     (data_line),
        .header_line   (header_line)
    );

    // Header index doubles as the next write position
    fth_commit_sequencer fth_commit_sequencer_i (
        .clk             (clk),
        .resetb          (resetb),
        .status          (status),
        .tx_enable       (tx_enable),
        .wr_grant        (wr_grant),
        .next_data_idx   (next_data_idx),
        .oldest_line_idx (oldest_line_idx),
        .state           (state),
        .header_idx      (next_write_line_idx),
        .tx_rdy          (tx_rdy)
    );

    fth_write_port fth_write_port_i (
        .state       (state),
        .status      (status),
        .header_idx  (next_write_line_idx),
        .ring_base   (ring_base),
        .data_line   (data_line),
        .header_line (header_line),
        .wr_req      (wr_req)
    );

endmodule

//--- include/fth_tb_model.svh
// Include inside a testbench module that imports fth_pkg; host image is indexed by ring position
`ifndef FTH_TB_MODEL_SVH
`define FTH_TB_MODEL_SVH

// Host address of a ring position
function automatic addr_t model_addr(input addr_t base, input line_idx_t idx);
    return base + addr_t'(idx);
endfunction

// Lines used by a message of n chunks, header included
function automatic int model_lines(input int n);
    // Header carries CHUNKS_PER_LINE - 1 chunks after its count slot
    // Each further started group of CHUNKS_PER_LINE adds one data line
    return 1 + n / CHUNKS_PER_LINE;
endfunction

// Header position of the message after this one
function automatic line_idx_t model_next_idx(input line_idx_t header_idx, input int n);
    return header_idx + line_idx_t'(model_lines(n));
endfunction

// Chunk list of one message, read in ring order from its header
function automatic void model_decode(input line_t mem [RING_LINES],
                                     input line_idx_t header_idx,
                                     output chunk_t chunks [$]);
    int unsigned n;
    int unsigned max_n;
    line_idx_t idx;
    int slot;

    n = mem[header_idx][0];
    // Bound the walk so a corrupt count cannot run away
    max_n = (LINE_LIMIT + 1) * CHUNKS_PER_LINE - 1;
    if (n > max_n)
    begin
        n = max_n;
    end
    chunks = {};
    idx = header_idx;
    slot = 1;
    while (chunks.size() < n)
    begin
        chunks.push_back(mem[idx][slot]);
        slot++;
        if (slot == CHUNKS_PER_LINE)
        begin
            slot = 0;
            idx = idx + 1'b1;
        end
    end
endfunction

`endif

//--- tb/fth_tb.sv
// Self-checking testbench; host consumes each message at once unless the ring is being held full
`timescale 1ns/100ps

module fth_tb
    import fth_pkg::*;
;

    `include "fth_tb_model.svh"

    // ====================
    // Test constants
    // ====================

    localparam time CLK_PERIOD = 20ns;
    localparam int  RESET_CYCLES = 5;
    localparam int  RT_MESSAGES = 12;
    localparam int  RT_MAX_CHUNKS = 30;
    localparam int  LIMIT_CHUNKS = 100;
    localparam int  FULL_CHUNKS = 80;
    localparam int  FULL_HOLD_CYCLES = 400;
    localparam int  TOTAL_CHUNKS = RT_MESSAGES * RT_MAX_CHUNKS + LIMIT_CHUNKS + FULL_CHUNKS;
    localparam addr_t RING_BASE = 16'h0a40;

    logic      clk;
    logic      resetb;
    chunk_t    tx_data;
    logic      tx_enable;
    logic      tx_rdy;
    addr_t     ring_base;
    line_idx_t oldest_line_idx;
    wr_req_t   wr_req;
    logic      wr_grant;
    line_idx_t next_write_line_idx;

    int        seed = 13;

    // Host side bookkeeping
    line_t     host_mem [RING_LINES];
    chunk_t    sent [$];
    count_t    len_q [$];
    chunk_t    msg_chunks [$];
    count_t    msg_count;
    line_idx_t exp_hdr = '0;
    int        data_count = 0;
    logic      after_header = 1'b0;
    logic      idx_pending = 1'b0;
    logic      follow = 1'b1;
    int        hold_lines = 0;
    int        grant_wait = 0;
    event      msg_done;

    fth_top fth_top_i (
        .clk                 (clk),
        .resetb              (resetb),
        .tx_data             (tx_data),
        .tx_enable           (tx_enable),
        .tx_rdy              (tx_rdy),
        .ring_base           (ring_base),
        .oldest_line_idx     (oldest_line_idx),
        .wr_req              (wr_req),
        .wr_grant            (wr_grant),
        .next_write_line_idx (next_write_line_idx)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ====================
    // Reference and checks
    // ====================

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_chunk(input string name, input chunk_t got, input chunk_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_kind(input string name, input wr_kind_t got, input wr_kind_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %s expected %s", $time, name,
                               got.name(), exp.name()));
        end
    endtask

    task automatic check_idx(input string name, input line_idx_t got, input line_idx_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            fail_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // ====================
    // Host model
    // ====================

    // Grant after a random 0 to 3 cycle wait per request
    always @(posedge clk)
    begin
        #2;
        if (!wr_req.request)
        begin
            wr_grant = 1'b0;
            grant_wait = -1;
        end
        else
        begin
            if (wr_grant || grant_wait < 0)
            begin
                grant_wait = $unsigned($random(seed)) % 4;
            end
            else
            begin
                grant_wait = grant_wait - 1;
            end
            wr_grant = (grant_wait == 0);
        end
        if (follow)
        begin
            oldest_line_idx = next_write_line_idx;
        end
    end

    // Mid-cycle sampling, all DUT outputs settled
    always @(negedge clk)
    begin
        if (idx_pending)
        begin
            idx_pending = 1'b0;
            check_idx("next_write_line_idx", next_write_line_idx, exp_hdr);
        end
        if (resetb && wr_req.request && wr_grant)
        begin
            case (wr_req.kind)
                WR_DATA:
                begin
                    check_bit("data after header", after_header, 1'b0);
                    check_addr("wr_req.addr", wr_req.addr,
                               model_addr(ring_base, exp_hdr + line_idx_t'(1 + data_count)));
                    host_mem[exp_hdr + line_idx_t'(1 + data_count)] = wr_req.line;
                    data_count++;
                    if (!follow)
                    begin
                        hold_lines++;
                    end
                end
                WR_HEADER:
                begin
                    check_bit("second header", after_header, 1'b0);
                    check_addr("wr_req.addr", wr_req.addr, model_addr(ring_base, exp_hdr));
                    host_mem[exp_hdr] = wr_req.line;
                    after_header = 1'b1;
                    if (!follow)
                    begin
                        hold_lines++;
                    end
                    if (data_count + 1 > LINE_LIMIT + 1)
                    begin
                        fail_run("message holds more lines than the line limit allows");
                    end
                end
                default:
                begin
                    check_kind("wr_req.kind", wr_req.kind, WR_FENCE);
                    check_bit("header before fence", after_header, 1'b1);
                    check_addr("fence wr_req.addr", wr_req.addr, '0);
                    model_decode(host_mem, exp_hdr, msg_chunks);
                    msg_count = count_t'(host_mem[exp_hdr][0]);
                    check_idx("message lines", line_idx_t'(data_count + 1),
                              line_idx_t'(model_lines(int'(msg_count))));
                    exp_hdr = model_next_idx(exp_hdr, int'(msg_count));
                    data_count = 0;
                    after_header = 1'b0;
                    idx_pending = 1'b1;
                    -> msg_done;
                end
            endcase
            if (!follow && hold_lines >= RING_LINES)
            begin
                fail_run("ring overrun while oldest line was held");
            end
        end
    end

    // Decoded messages against the chunks the stream sent
    initial
    begin
        forever
        begin
            @(msg_done);
            if (len_q.size() > 0)
            begin
                check_count("header count", msg_count, len_q.pop_front());
            end
            foreach (msg_chunks[i])
            begin
                if (sent.size() == 0)
                begin
                    fail_run("message holds more chunks than were sent");
                end
                check_chunk("decoded chunk", msg_chunks[i], sent.pop_front());
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic send_chunk(input chunk_t c);
        @(posedge clk);
        #2;
        tx_enable = 1'b0;
        while (!tx_rdy)
        begin
            @(posedge clk);
            #2;
        end
        tx_data = c;
        tx_enable = 1'b1;
        sent.push_back(c);
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        #2;
        tx_enable = 1'b0;
        repeat (cycles)
        begin
            @(posedge clk);
        end
    endtask

    // Waits until every sent chunk came back through a message
    task automatic drain();
        while (sent.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (4)
        begin
            @(posedge clk);
        end
    endtask

    initial
    begin
        int n;
        resetb = 1'b0;
        tx_data = '0;
        tx_enable = 1'b0;
        ring_base = RING_BASE;
        oldest_line_idx = '0;
        wr_grant = 1'b0;

        // Reset values held through reset and the cycle after
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_bit("wr_req.request", wr_req.request, 1'b0);
            check_bit("tx_rdy", tx_rdy, 1'b0);
            check_idx("next_write_line_idx", next_write_line_idx, '0);
        end
        @(posedge clk);
        #2;
        resetb = 1'b1;
        @(negedge clk);
        check_bit("wr_req.request", wr_req.request, 1'b0);
        check_bit("tx_rdy", tx_rdy, 1'b0);
        check_idx("next_write_line_idx", next_write_line_idx, '0);

        // Round trip, each message closed by the idle timer
        repeat (RT_MESSAGES)
        begin
            n = 1 + $unsigned($random(seed)) % RT_MAX_CHUNKS;
            len_q.push_back(count_t'(n));
            repeat (n)
            begin
                send_chunk($random(seed));
            end
            go_idle(IDLE_LIMIT + 4);
            drain();
        end

        // Unbroken stream split by the line limit
        repeat (LIMIT_CHUNKS)
        begin
            send_chunk($random(seed));
        end
        go_idle(IDLE_LIMIT + 4);
        drain();

        // Oldest line held so the ring fills, then released
        @(posedge clk);
        #2;
        follow = 1'b0;
        hold_lines = 0;
        fork
            begin
                repeat (FULL_CHUNKS)
                begin
                    send_chunk($random(seed));
                end
                go_idle(IDLE_LIMIT + 4);
            end
            begin
                repeat (FULL_HOLD_CYCLES)
                begin
                    @(posedge clk);
                end
                #2;
                // A full ring keeps the source blocked until oldest moves
                if (tx_rdy !== 1'b0)
                begin
                    fail_run("stream never stalled on a full ring");
                end
                follow = 1'b1;
            end
        join
        drain();

        $display("all tests passed");
        $finish;
    end

    // Watchdog sized from the total stream length
    initial
    begin
        #(CLK_PERIOD * (TOTAL_CHUNKS * 40 + 2000));
        fail_run("watchdog timeout, the run did not finish in time");
    end

endmodule

//--- build.f
+incdir+include
source/fth_pkg.sv
source/fth_chunk_packer.sv
source/fth_commit_sequencer.sv
source/fth_write_port.sv
source/fth_top.sv
tb/fth_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module fth_tb -o fth_tb_sim &&
./obj_dir/fth_tb_sim ||
{ echo "simulation failed"; exit 1; }
